// ==== Bender.yml ====
package:
  name: gat_mem

sources:
  - files:
      - rtl/gat_pkg.sv
      - rtl/bram.sv
      - rtl/axil_load_port.sv
      - rtl/memory_controller.sv
      - rtl/wh_engine.sv
      - rtl/gat_mem_top.sv
  - target: test
    files:
      - testbench/tb_gat_mem.sv

// ==== build.f ====
rtl/gat_pkg.sv
rtl/bram.sv
rtl/axil_load_port.sv
rtl/memory_controller.sv
rtl/wh_engine.sv
rtl/gat_mem_top.sv
testbench/tb_gat_mem.sv

// ==== rtl/axil_load_port.sv ====
// ==========================================================
// AXI4-Lite slave for the GAT memory subsystem
// Turns host writes into store loads, serves control,
// status and WH result reads
// ==========================================================
`timescale 1ns/1ps

module axil_load_port (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [gat_pkg::AXI_ADDR_W-1:0] awaddr,
  input  logic                           awvalid,
  output logic                           awready,
  input  logic [31:0]                    wdata,
  input  logic                           wvalid,
  output logic                           wready,
  output logic [1:0]                     bresp,
  output logic                           bvalid,
  input  logic                           bready,
  input  logic [gat_pkg::AXI_ADDR_W-1:0] araddr,
  input  logic                           arvalid,
  output logic                           arready,
  output logic [31:0]                    rdata,
  output logic [1:0]                     rresp,
  output logic                           rvalid,
  input  logic                           rready,
  output gat_pkg::load_req_t             load_req,
  output logic                           start,
  output logic                           gat_layer,
  input  logic                           busy,
  input  logic                           done_pulse,
  output gat_pkg::node_addr_t            wh_rd_addr,
  input  gat_pkg::wh_row_t               wh_rd_row
);

  import gat_pkg::*;

  typedef enum logic {
    RD_IDLE,
    RD_WAIT
  } rd_state_e;

  rd_state_e             rd_state;
  logic                  wr_hs;
  logic                  rd_hs;
  logic                  wr_ctrl;
  logic                  wr_status;
  logic                  wr_store;
  logic                  wr_err;
  store_sel_e            wr_sel;
  logic                  done;
  logic [AXI_ADDR_W-1:0] rd_addr_q;
  logic [31:0]           rd_data;
  logic                  rd_err;

  function automatic logic in_region(input logic [AXI_ADDR_W-1:0] addr,
                                     input int base, input int words);
    return (int'(addr) >= base) && (int'(addr) < base + 4 * words);
  endfunction

  // ==========================================================
  // Write channel
  // ==========================================================
  assign wr_hs   = awvalid && wvalid && !bvalid;
  assign awready = wr_hs;
  assign wready  = wr_hs;

  assign wr_ctrl   = (int'(awaddr) == ADDR_CTRL);
  assign wr_status = (int'(awaddr) == ADDR_STATUS);

  always_comb begin
    wr_store = 1'b1;
    wr_sel   = SEL_H_DATA;
    if (in_region(awaddr, ADDR_NODE_BASE, TOTAL_NODES)) begin
      wr_sel = SEL_NODE_INFO;
    end else if (in_region(awaddr, ADDR_WGT_BASE, WEIGHT_DEPTH)) begin
      wr_sel = SEL_WEIGHT;
    end else if (!in_region(awaddr, ADDR_H_BASE, H_NUM_SPARSE_DATA)) begin
      wr_store = 1'b0;
    end
  end

  // Unmapped, or touching stores and start during a run
  assign wr_err = !(wr_ctrl || wr_status || wr_store) || (busy && (wr_ctrl || wr_store));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bvalid         <= 1'b0;
      bresp          <= RESP_OKAY;
      start          <= 1'b0;
      gat_layer      <= 1'b0;
      done           <= 1'b0;
      load_req.valid <= 1'b0;
    end else begin
      start          <= 1'b0;
      load_req.valid <= 1'b0;
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
      if (done_pulse) begin
        done <= 1'b1;
      end
      if (wr_hs) begin
        bvalid        <= 1'b1;
        bresp         <= wr_err ? RESP_SLVERR : RESP_OKAY;
        load_req.sel  <= wr_sel;
        load_req.addr <= awaddr[2 +: LOAD_ADDR_W];
        load_req.data <= wdata;
        if (!wr_err && wr_store) begin
          load_req.valid <= 1'b1;
        end
        if (!wr_err && wr_ctrl) begin
          start     <= wdata[0];
          gat_layer <= wdata[1];
          if (wdata[0]) begin
            done <= 1'b0;
          end
        end
      end
    end
  end

  // ==========================================================
  // Read channel
  // ==========================================================
  assign arready = (rd_state == RD_IDLE) && !rvalid;
  assign rd_hs   = arvalid && arready;

  // WH word index is node * 2 + feature
  assign wh_rd_addr = araddr[3 +: NODE_INFO_ADDR_W];

  always_comb begin
    rd_data = '0;
    rd_err  = 1'b0;
    if (int'(rd_addr_q) == ADDR_CTRL) begin
      rd_data[1] = gat_layer;
    end else if (int'(rd_addr_q) == ADDR_STATUS) begin
      rd_data[1:0] = {done, busy};
    end else if (in_region(rd_addr_q, ADDR_WH_BASE, WH_WORDS)) begin
      rd_data = 32'(wh_rd_row.f[rd_addr_q[2]]);
    end else begin
      rd_err = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_state <= RD_IDLE;
      rvalid   <= 1'b0;
      rresp    <= RESP_OKAY;
      rdata    <= '0;
    end else begin
      if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
      case (rd_state)
        RD_IDLE: begin
          if (rd_hs) begin
            rd_addr_q <= araddr;
            rd_state  <= RD_WAIT;
          end
        end
        RD_WAIT: begin
          rvalid   <= 1'b1;
          rresp    <= rd_err ? RESP_SLVERR : RESP_OKAY;
          rdata    <= rd_data;
          rd_state <= RD_IDLE;
        end
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid && $stable(bresp));

  a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

// ==== rtl/bram.sv ====
// ==========================================================
// Simple dual-port block RAM
// One write port, one registered read port
// ==========================================================
`timescale 1ns/1ps

module bram #(
  parameter int DATA_WIDTH = 8,
  parameter int DEPTH      = 16
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [DATA_WIDTH-1:0]    din,
  input  logic [$clog2(DEPTH)-1:0] addra,
  input  logic                     ena,
  input  logic [$clog2(DEPTH)-1:0] addrb,
  output logic [DATA_WIDTH-1:0]    dout
);

  logic [DATA_WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (ena) begin
      mem[addra] <= din;
    end
  end

  // Read data lands one cycle after the address
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dout <= '0;
    end else begin
      dout <= mem[addrb];
    end
  end

  a_write_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    ena |-> (addra < DEPTH));

endmodule

// ==== rtl/gat_mem_top.sv ====
// ==========================================================
// GAT memory subsystem top level
// Host bus port, memory controller and WH engine
// ==========================================================
`timescale 1ns/1ps

module gat_mem_top (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [gat_pkg::AXI_ADDR_W-1:0] awaddr,
  input  logic                           awvalid,
  output logic                           awready,
  input  logic [31:0]                    wdata,
  input  logic                           wvalid,
  output logic                           wready,
  output logic [1:0]                     bresp,
  output logic                           bvalid,
  input  logic                           bready,
  input  logic [gat_pkg::AXI_ADDR_W-1:0] araddr,
  input  logic                           arvalid,
  output logic                           arready,
  output logic [31:0]                    rdata,
  output logic [1:0]                     rresp,
  output logic                           rvalid,
  input  logic                           rready
);

  import gat_pkg::*;

  load_req_t  load_req;
  logic       start;
  logic       gat_layer;
  logic       busy;
  logic       done_pulse;
  node_addr_t wh_rd_addr;
  wh_row_t    wh_rd_row;
  node_addr_t node_addr;
  row_len_t   node_info;
  h_addr_t    h_addr;
  h_entry_t   h_entry;
  col_idx_t   wgt_row_addr;
  wgt_row_t   wgt_row;
  logic       wh_wr_en;
  node_addr_t wh_wr_addr;
  wh_row_t    wh_wr_row;

  axil_load_port load_port_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wvalid     (wvalid),
    .wready     (wready),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .bready     (bready),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rvalid     (rvalid),
    .rready     (rready),
    .load_req   (load_req),
    .start      (start),
    .gat_layer  (gat_layer),
    .busy       (busy),
    .done_pulse (done_pulse),
    .wh_rd_addr (wh_rd_addr),
    .wh_rd_row  (wh_rd_row)
  );

  memory_controller mem_ctrl_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .gat_layer    (gat_layer),
    .load_req     (load_req),
    .node_addr    (node_addr),
    .node_info    (node_info),
    .h_addr       (h_addr),
    .h_entry      (h_entry),
    .wgt_row_addr (wgt_row_addr),
    .wgt_row      (wgt_row),
    .wh_wr_en     (wh_wr_en),
    .wh_wr_addr   (wh_wr_addr),
    .wh_wr_row    (wh_wr_row),
    .wh_rd_addr   (wh_rd_addr),
    .wh_rd_row    (wh_rd_row)
  );

  wh_engine wh_engine_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .busy         (busy),
    .done_pulse   (done_pulse),
    .node_addr    (node_addr),
    .node_info    (node_info),
    .h_addr       (h_addr),
    .h_entry      (h_entry),
    .wgt_row_addr (wgt_row_addr),
    .wgt_row      (wgt_row),
    .wh_wr_en     (wh_wr_en),
    .wh_wr_addr   (wh_wr_addr),
    .wh_wr_row    (wh_wr_row)
  );

endmodule

// ==== rtl/gat_pkg.sv ====
// ==========================================================
// GAT memory subsystem shared definitions
// Sizes, value types, host address map and bundle structs
// ==========================================================
package gat_pkg;

  // Problem sizes
  localparam int DATA_WIDTH        = 8;
  localparam int NUM_FEATURE_IN    = 8;
  localparam int NUM_FEATURE_OUT   = 2;
  localparam int TOTAL_NODES       = 8;
  localparam int H_NUM_SPARSE_DATA = 32;
  localparam int WH_DATA_WIDTH     = 20;
  localparam int NUM_LAYERS        = 2;

  // Derived widths and depths
  localparam int COL_IDX_WIDTH    = $clog2(NUM_FEATURE_IN);
  localparam int ROW_LEN_WIDTH    = $clog2(NUM_FEATURE_IN + 1);
  localparam int H_DATA_ADDR_W    = $clog2(H_NUM_SPARSE_DATA);
  localparam int NODE_INFO_ADDR_W = $clog2(TOTAL_NODES);
  localparam int WEIGHT_DEPTH     = NUM_LAYERS * NUM_FEATURE_IN;
  localparam int WEIGHT_ADDR_W    = $clog2(WEIGHT_DEPTH);
  localparam int WH_WORDS         = TOTAL_NODES * NUM_FEATURE_OUT;
  localparam int LOAD_ADDR_W      = H_DATA_ADDR_W;

  // ==========================================================
  // Host address map, byte offsets
  // ==========================================================
  localparam int AXI_ADDR_W     = 12;
  localparam int ADDR_CTRL      = 'h000;
  localparam int ADDR_STATUS    = 'h004;
  localparam int ADDR_NODE_BASE = 'h100;
  localparam int ADDR_H_BASE    = 'h200;
  localparam int ADDR_WGT_BASE  = 'h400;
  localparam int ADDR_WH_BASE   = 'h800;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef logic signed [DATA_WIDTH-1:0]    data_t;
  typedef logic [COL_IDX_WIDTH-1:0]        col_idx_t;
  typedef logic [ROW_LEN_WIDTH-1:0]        row_len_t;
  typedef logic signed [WH_DATA_WIDTH-1:0] wh_elem_t;
  typedef logic [H_DATA_ADDR_W-1:0]        h_addr_t;
  typedef logic [NODE_INFO_ADDR_W-1:0]     node_addr_t;
  typedef logic [WEIGHT_ADDR_W-1:0]        wgt_addr_t;

  typedef enum logic [1:0] {
    SEL_H_DATA,
    SEL_NODE_INFO,
    SEL_WEIGHT
  } store_sel_e;

  // Value in the upper bits, column below it
  typedef struct packed {
    data_t    value;
    col_idx_t col;
  } h_entry_t;

  // Element 0 in the low byte
  typedef struct packed {
    data_t [NUM_FEATURE_OUT-1:0] w;
  } wgt_row_t;

  typedef struct packed {
    wh_elem_t [NUM_FEATURE_OUT-1:0] f;
  } wh_row_t;

  typedef struct packed {
    logic                   valid;
    store_sel_e             sel;
    logic [LOAD_ADDR_W-1:0] addr;
    logic [31:0]            data;
  } load_req_t;

endpackage

// ==== rtl/memory_controller.sv ====
// ==========================================================
// GAT memory controller
// H data, node info, weight and WH block RAMs, with
// host load steering and layer-banked weight reads
// ==========================================================
`timescale 1ns/1ps

module memory_controller (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                gat_layer,
  input  gat_pkg::load_req_t  load_req,
  input  gat_pkg::node_addr_t node_addr,
  output gat_pkg::row_len_t   node_info,
  input  gat_pkg::h_addr_t    h_addr,
  output gat_pkg::h_entry_t   h_entry,
  input  gat_pkg::col_idx_t   wgt_row_addr,
  output gat_pkg::wgt_row_t   wgt_row,
  input  logic                wh_wr_en,
  input  gat_pkg::node_addr_t wh_wr_addr,
  input  gat_pkg::wh_row_t    wh_wr_row,
  input  gat_pkg::node_addr_t wh_rd_addr,
  output gat_pkg::wh_row_t    wh_rd_row
);

  import gat_pkg::*;

  logic      h_we;
  logic      node_we;
  logic      wgt_we;
  wgt_addr_t wgt_rd_addr;

  assign h_we    = load_req.valid && (load_req.sel == SEL_H_DATA);
  assign node_we = load_req.valid && (load_req.sel == SEL_NODE_INFO);
  assign wgt_we  = load_req.valid && (load_req.sel == SEL_WEIGHT);

  // Layer picks the upper half of the weight store
  assign wgt_rd_addr = {gat_layer, wgt_row_addr};

  // ==========================================================
  // Block RAMs
  // ==========================================================
  bram #(
    .DATA_WIDTH ($bits(h_entry_t)),
    .DEPTH      (H_NUM_SPARSE_DATA)
  ) h_data_bram_i (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (load_req.data[$bits(h_entry_t)-1:0]),
    .addra (load_req.addr[H_DATA_ADDR_W-1:0]),
    .ena   (h_we),
    .addrb (h_addr),
    .dout  (h_entry)
  );

  bram #(
    .DATA_WIDTH (ROW_LEN_WIDTH),
    .DEPTH      (TOTAL_NODES)
  ) node_info_bram_i (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (load_req.data[ROW_LEN_WIDTH-1:0]),
    .addra (load_req.addr[NODE_INFO_ADDR_W-1:0]),
    .ena   (node_we),
    .addrb (node_addr),
    .dout  (node_info)
  );

  bram #(
    .DATA_WIDTH ($bits(wgt_row_t)),
    .DEPTH      (WEIGHT_DEPTH)
  ) wgt_bram_i (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (load_req.data[$bits(wgt_row_t)-1:0]),
    .addra (load_req.addr[WEIGHT_ADDR_W-1:0]),
    .ena   (wgt_we),
    .addrb (wgt_rd_addr),
    .dout  (wgt_row)
  );

  bram #(
    .DATA_WIDTH ($bits(wh_row_t)),
    .DEPTH      (TOTAL_NODES)
  ) wh_bram_i (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (wh_wr_row),
    .addra (wh_wr_addr),
    .ena   (wh_wr_en),
    .addrb (wh_rd_addr),
    .dout  (wh_rd_row)
  );

endmodule

// ==== rtl/wh_engine.sv ====
// ==========================================================
// WH engine
// Walks the sparse H rows node by node and accumulates
// one WH = H x W row per node into the WH store
// ==========================================================
`timescale 1ns/1ps

module wh_engine (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,
  output logic                busy,
  output logic                done_pulse,
  output gat_pkg::node_addr_t node_addr,
  input  gat_pkg::row_len_t   node_info,
  output gat_pkg::h_addr_t    h_addr,
  input  gat_pkg::h_entry_t   h_entry,
  output gat_pkg::col_idx_t   wgt_row_addr,
  input  gat_pkg::wgt_row_t   wgt_row,
  output logic                wh_wr_en,
  output gat_pkg::node_addr_t wh_wr_addr,
  output gat_pkg::wh_row_t    wh_wr_row
);

  import gat_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_READ_INFO,
    S_WAIT_INFO,
    S_READ_ENTRY,
    S_WAIT_WEIGHT,
    S_ACCUMULATE,
    S_WRITE_ROW
  } state_e;

  state_e                      state;
  node_addr_t                  node;
  logic [H_DATA_ADDR_W:0]      ptr;
  row_len_t                    remaining;
  data_t                       entry_val;
  wh_row_t                     acc;
  logic                        last_node;
  logic signed [2*DATA_WIDTH-1:0] prod [NUM_FEATURE_OUT];

  assign busy         = (state != S_IDLE);
  assign last_node    = (node == node_addr_t'(TOTAL_NODES - 1));
  assign node_addr    = node;
  assign h_addr       = ptr[H_DATA_ADDR_W-1:0];
  // Column straight from the H RAM output
  assign wgt_row_addr = h_entry.col;
  assign wh_wr_en     = (state == S_WRITE_ROW);
  assign wh_wr_addr   = node;
  assign wh_wr_row    = acc;
  assign done_pulse   = wh_wr_en && last_node;

  always_comb begin
    for (int i = 0; i < NUM_FEATURE_OUT; i++) begin
      prod[i] = entry_val * wgt_row.w[i];
    end
  end

  // ==========================================================
  // Control FSM
  // ==========================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= S_IDLE;
      node      <= '0;
      ptr       <= '0;
      remaining <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (start) begin
            node  <= '0;
            ptr   <= '0;
            state <= S_READ_INFO;
          end
        end
        S_READ_INFO: state <= S_WAIT_INFO;
        S_WAIT_INFO: begin
          remaining <= node_info;
          acc       <= '0;
          // Empty row goes straight to a zero write
          state     <= (node_info == '0) ? S_WRITE_ROW : S_READ_ENTRY;
        end
        S_READ_ENTRY: state <= S_WAIT_WEIGHT;
        S_WAIT_WEIGHT: begin
          entry_val <= h_entry.value;
          state     <= S_ACCUMULATE;
        end
        S_ACCUMULATE: begin
          for (int i = 0; i < NUM_FEATURE_OUT; i++) begin
            acc.f[i] <= acc.f[i] + wh_elem_t'(prod[i]);
          end
          ptr       <= ptr + 1'b1;
          remaining <= remaining - 1'b1;
          state     <= (remaining == row_len_t'(1)) ? S_WRITE_ROW : S_READ_ENTRY;
        end
        S_WRITE_ROW: begin
          if (last_node) begin
            state <= S_IDLE;
          end else begin
            node  <= node + 1'b1;
            state <= S_READ_INFO;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Row lengths loaded by the host must fit the sparse store
  a_ptr_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    busy |-> (ptr <= H_NUM_SPARSE_DATA));

endmodule

// ==== testbench/tb_gat_mem.sv ====
// ==========================================================
// Testbench for the GAT memory subsystem
// Loads random stores over AXI4-Lite, runs both layers and
// checks WH results against a reference model
// ==========================================================
`timescale 1ns/1ps

module tb_gat_mem;

  import gat_pkg::*;

  // Engine budget per run, plus bus traffic and reset
  localparam int RUN_CYCLES     = 4 * (H_NUM_SPARSE_DATA * 6 + TOTAL_NODES * 4);
  localparam int BUS_CYCLES     = 160 * 8;
  localparam int TIMEOUT_CYCLES = 16 + RUN_CYCLES + BUS_CYCLES;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic [AXI_ADDR_W-1:0] awaddr;
  logic                  awvalid;
  logic                  awready;
  logic [31:0]           wdata;
  logic                  wvalid;
  logic                  wready;
  logic [1:0]            bresp;
  logic                  bvalid;
  logic                  bready;
  logic [AXI_ADDR_W-1:0] araddr;
  logic                  arvalid;
  logic                  arready;
  logic [31:0]           rdata;
  logic [1:0]            rresp;
  logic                  rvalid;
  logic                  rready;

  int          cycle_count = 0;
  int          value_errors = 0;
  int          resp_errors = 0;
  int          proto_errors = 0;
  int          neg_seen = 0;
  logic [15:0] lfsr = 16'd38;

  // Testbench copies of the stores
  int h_val   [H_NUM_SPARSE_DATA];
  int h_col   [H_NUM_SPARSE_DATA];
  int row_len [TOTAL_NODES];
  int wgt     [NUM_LAYERS][NUM_FEATURE_IN][NUM_FEATURE_OUT];

  gat_mem_top dut_i (.*);

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  initial begin
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("Timeout after %0d cycles, the DUT stopped responding", cycle_count);
    $display("Simulation failed");
    $finish;
  end

  // 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  // Expected WH element from the testbench stores
  function automatic int ref_wh(input int layer, input int node, input int feat);
    int ptr;
    int acc;
    ptr = 0;
    acc = 0;
    for (int n = 0; n < node; n++) begin
      ptr += row_len[n];
    end
    for (int e = 0; e < row_len[node]; e++) begin
      acc += h_val[ptr + e] * wgt[layer][h_col[ptr + e]][feat];
    end
    return acc;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      value_errors++;
      $display("FAIL %s: expected 0x%08h, got 0x%08h", name, exp, act);
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) begin
      resp_errors++;
      $display("FAIL %s: expected resp %0d, got resp %0d", name, exp, act);
    end
  endtask

  // ==========================================================
  // Bus tasks, entered and left on a falling edge
  // ==========================================================
  task automatic axi_write(input int addr, input logic [31:0] data, input int hold,
                           output logic [1:0] resp);
    awaddr  = AXI_ADDR_W'(addr);
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    // Ready lines seen at the rising edge that takes the handshake
    do begin
      @(posedge clk);
      if (awready !== wready) begin
        proto_errors++;
        $display("awready and wready did not rise together");
      end
    end while (!(awready && wready));
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) @(negedge clk);
    resp    = bresp;
    repeat (hold) begin
      @(negedge clk);
      if (!bvalid || bresp !== resp) begin
        proto_errors++;
        $display("Write response was not held while bready was low");
      end
    end
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axi_read(input int addr, input int hold, output logic [31:0] data,
                          output logic [1:0] resp);
    araddr  = AXI_ADDR_W'(addr);
    arvalid = 1'b1;
    do @(negedge clk); while (arready);
    arvalid = 1'b0;
    while (!rvalid) @(negedge clk);
    data = rdata;
    resp = rresp;
    repeat (hold) begin
      @(negedge clk);
      if (!rvalid || rdata !== data || rresp !== resp) begin
        proto_errors++;
        $display("Read data was not held while rready was low");
      end
    end
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
  endtask

  task automatic build_stores();
    int total;
    int len;
    total = 0;
    for (int n = 0; n < TOTAL_NODES; n++) begin
      len = random_bits(4) % (NUM_FEATURE_IN + 1);
      if (total + len > H_NUM_SPARSE_DATA) len = H_NUM_SPARSE_DATA - total;
      // One empty row on purpose
      if (n == 3) len = 0;
      row_len[n] = len;
      total += len;
    end
    for (int i = 0; i < H_NUM_SPARSE_DATA; i++) begin
      h_val[i] = byte'(random_bits(8));
      h_col[i] = random_bits(COL_IDX_WIDTH);
    end
    for (int l = 0; l < NUM_LAYERS; l++)
      for (int r = 0; r < NUM_FEATURE_IN; r++)
        for (int f = 0; f < NUM_FEATURE_OUT; f++)
          wgt[l][r][f] = byte'(random_bits(8));
  endtask

  task automatic load_stores();
    logic [1:0] resp;
    for (int n = 0; n < TOTAL_NODES; n++) begin
      axi_write(ADDR_NODE_BASE + 4 * n, 32'(row_len[n]), 0, resp);
      check_resp("load", RESP_OKAY, resp);
    end
    for (int i = 0; i < H_NUM_SPARSE_DATA; i++) begin
      axi_write(ADDR_H_BASE + 4 * i, {21'b0, 8'(h_val[i]), 3'(h_col[i])}, 0, resp);
      check_resp("load", RESP_OKAY, resp);
    end
    for (int l = 0; l < NUM_LAYERS; l++) begin
      for (int r = 0; r < NUM_FEATURE_IN; r++) begin
        axi_write(ADDR_WGT_BASE + 4 * (l * NUM_FEATURE_IN + r),
                  {16'b0, 8'(wgt[l][r][1]), 8'(wgt[l][r][0])}, 0, resp);
        check_resp("load", RESP_OKAY, resp);
      end
    end
  endtask

  task automatic wait_done(input string name);
    logic [31:0] data;
    logic [1:0]  resp;
    data = '0;
    while (!data[1]) axi_read(ADDR_STATUS, 0, data, resp);
    if (data[0]) begin
      proto_errors++;
      $display("%s: status shows busy together with done", name);
    end
  endtask

  task automatic compare_wh(input int layer, input string name);
    logic [31:0] data;
    logic [1:0]  resp;
    int          exp;
    for (int n = 0; n < TOTAL_NODES; n++) begin
      for (int f = 0; f < NUM_FEATURE_OUT; f++) begin
        exp = ref_wh(layer, n, f);
        if (exp < 0) neg_seen++;
        axi_read(ADDR_WH_BASE + 4 * (n * NUM_FEATURE_OUT + f), 0, data, resp);
        check_resp(name, RESP_OKAY, resp);
        check_value(name, 32'(exp), data);
      end
    end
  endtask

  // ==========================================================
  // Test sequence
  // ==========================================================
  initial begin
    logic [31:0] data;
    logic [1:0]  resp;
    rst_n   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    if (bvalid || rvalid || !arready) begin
      proto_errors++;
      $display("Bus outputs are not in their reset state");
    end

    build_stores();
    load_stores();

    // Layer 0, then layer 1 on the same H data
    axi_write(ADDR_CTRL, 32'h1, 0, resp);
    check_resp("layer0", RESP_OKAY, resp);
    wait_done("layer0");
    compare_wh(0, "layer0");
    axi_write(ADDR_CTRL, 32'h3, 0, resp);
    check_resp("layer1", RESP_OKAY, resp);
    wait_done("layer1");
    compare_wh(1, "layer1");

    // Store and start writes during a run are refused
    axi_write(ADDR_CTRL, 32'h1, 0, resp);
    check_resp("busy_write", RESP_OKAY, resp);
    axi_write(ADDR_H_BASE, 32'h7ff, 0, resp);
    check_resp("busy_write", RESP_SLVERR, resp);
    axi_write(ADDR_CTRL, 32'h3, 0, resp);
    check_resp("busy_write", RESP_SLVERR, resp);
    wait_done("busy_write");
    axi_read(ADDR_CTRL, 0, data, resp);
    check_value("busy_write", 32'h0, data);
    compare_wh(0, "busy_write");

    // Empty row reads back as zero
    for (int f = 0; f < NUM_FEATURE_OUT; f++) begin
      axi_read(ADDR_WH_BASE + 4 * (3 * NUM_FEATURE_OUT + f), 0, data, resp);
      check_value("zero_row", 32'h0, data);
    end
    if (neg_seen == 0) begin
      proto_errors++;
      $display("No negative WH result was exercised");
    end

    // Unmapped addresses
    axi_write('h040, 32'h1, 0, resp);
    check_resp("unmapped", RESP_SLVERR, resp);
    axi_read('h040, 0, data, resp);
    check_resp("unmapped", RESP_SLVERR, resp);
    axi_read(ADDR_WH_BASE + 4 * WH_WORDS, 0, data, resp);
    check_resp("unmapped", RESP_SLVERR, resp);

    // Ready held low for several cycles
    axi_write(ADDR_NODE_BASE, 32'(row_len[0]), 5, resp);
    check_resp("backpressure", RESP_OKAY, resp);
    axi_write('h0f0, 32'h0, 4, resp);
    check_resp("backpressure", RESP_SLVERR, resp);
    axi_read(ADDR_WH_BASE + 4, 5, data, resp);
    check_resp("backpressure", RESP_OKAY, resp);
    check_value("backpressure", 32'(ref_wh(0, 0, 1)), data);

    $display("Errors: value %0d, response %0d, protocol %0d",
             value_errors, resp_errors, proto_errors);
    if (value_errors + resp_errors + proto_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
